//--- filelist.f
cu_pkg.sv
cu_if.sv
cu_input_stage.sv
read_command_arbiter.sv
vertex_job_control.sv
vertex_job_filter.sv
graph_algorithm_control.sv
cu_completion.sv
cu_control.sv
tb_mem_model.sv
tb_cu_control.sv

//--- run.sh
#!/bin/bash
# build and run the compute unit control testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cu_control \
	-f filelist.f -o sim_cu_control
./obj_dir/sim_cu_control | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation failed"
	exit 1
fi

//--- tb_cu_control.sv
/* testbench for the compute unit control block with stimulus,
   reference values from the memory tables and checking assertions */

`timescale 1ns/100ps

module tb_cu_control;
	import cu_pkg::*;

	localparam int          NUM_VERTICES  = 24;
	localparam logic [31:0] VERTEX_BASE   = 32'h0001_0000;
	localparam logic [31:0] PROPERTY_BASE = 32'h0004_0000;
	localparam logic [31:0] SEED          = 32'h9af42094;
	localparam int          DONE_TIMEOUT  = 20000;
	localparam addr_t       TABLE_BYTES   = addr_t'(NUM_VERTICES * WORD_BYTES);

	logic   clock = 1'b0;
	logic   rstn;
	logic   enabled_in;
	logic   wed_valid;
	word_t  wed_num_vertices;
	word_t  wed_num_edges;
	addr_t  wed_vertex_base;
	addr_t  wed_property_base;
	word_t  cu_configure;
	logic   read_cmd_valid;
	addr_t  read_cmd_addr;
	cu_id_e read_cmd_cu_id;
	logic   read_buffer_full;
	logic   read_data_valid;
	cu_id_e read_data_cu_id;
	word_t  read_data;
	logic   write_cmd_valid;
	addr_t  write_cmd_addr;
	word_t  write_data;
	logic   write_buffer_full;
	logic   cu_done;
	word_t  cu_status;
	word_t  cu_return_vertices;
	word_t  cu_return_edges;

	logic                    setup_done;
	logic                    status_check;
	word_t                   expected_status;
	word_t                   expected_edges;
	logic [NUM_VERTICES-1:0] degree_seen;
	logic                    timed_out;
	int                      read_errors;
	int                      write_errors;
	int                      status_errors;
	int                      done_errors;
	int                      wait_count;

	always #10 clock = ~clock;

	cu_control i_dut (.*);

	tb_mem_model #(
		.NUM_VERTICES (NUM_VERTICES),
		.VERTEX_BASE  (VERTEX_BASE),
		.PROPERTY_BASE(PROPERTY_BASE),
		.SEED         (SEED)
	) i_mem (.*);

	////////////////////////////////////////
	// reference helpers
	////////////////////////////////////////

	function automatic logic in_table(input addr_t addr, input addr_t base);
		return (addr >= base) && (addr < base + TABLE_BYTES)
			&& ((addr - base) % addr_t'(WORD_BYTES) == '0);
	endfunction

	function automatic int vertex_index(input addr_t addr, input addr_t base);
		return int'((addr - base) / addr_t'(WORD_BYTES));
	endfunction

	function automatic word_t degree_at(input addr_t addr);
		if (!in_table(addr, PROPERTY_BASE)) begin
			return '0;
		end
		return i_mem.degree_table[vertex_index(addr, PROPERTY_BASE)];
	endfunction

	// property plus degree of the vertex whose property lives at addr
	function automatic word_t updated_property(input addr_t addr);
		int idx;
		if (!in_table(addr, PROPERTY_BASE)) begin
			return '0;
		end
		idx = vertex_index(addr, PROPERTY_BASE);
		return i_mem.property_table[idx] + i_mem.degree_table[idx];
	endfunction

	function automatic word_t degree_sum();
		word_t sum;
		sum = '0;
		for (int i = 0; i < NUM_VERTICES; i++) begin
			sum = sum + i_mem.degree_table[i];
		end
		return sum;
	endfunction

	always @(posedge clock) begin
		if (rstn && read_cmd_valid && read_cmd_cu_id == CU_ID_VERTEX_JOB
			&& in_table(read_cmd_addr, VERTEX_BASE)) begin
			degree_seen[vertex_index(read_cmd_addr, VERTEX_BASE)] <= 1'b1;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn) !setup_done |-> !read_cmd_valid)
		else begin
			read_errors++;
			$display("read command issued at %0t before the unit was set up", $time);
		end

	assert property (@(posedge clock) disable iff (!rstn) status_check
		|-> cu_status == expected_status)
		else begin
			status_errors++;
			$display("error at %0t: cu_status = %h, expected %h", $time,
				$sampled(cu_status), expected_status);
		end

	assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd_valid && read_cmd_cu_id == CU_ID_VERTEX_JOB)
		|-> in_table(read_cmd_addr, VERTEX_BASE))
		else begin
			read_errors++;
			$display("degree read at %0t to %h lies outside the degree table", $time,
				$sampled(read_cmd_addr));
		end

	assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd_valid && read_cmd_cu_id == CU_ID_ALGORITHM)
		|-> in_table(read_cmd_addr, PROPERTY_BASE))
		else begin
			read_errors++;
			$display("property read at %0t to %h lies outside the property table", $time,
				$sampled(read_cmd_addr));
		end

	assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd_valid && read_cmd_cu_id == CU_ID_VERTEX_JOB
		&& in_table(read_cmd_addr, VERTEX_BASE))
		|-> !degree_seen[vertex_index(read_cmd_addr, VERTEX_BASE)])
		else begin
			read_errors++;
			$display("degree at %h read a second time at %0t", $sampled(read_cmd_addr), $time);
		end

	assert property (@(posedge clock) disable iff (!rstn)
		write_cmd_valid |-> in_table(write_cmd_addr, PROPERTY_BASE))
		else begin
			write_errors++;
			$display("write at %0t to %h lies outside the property table", $time,
				$sampled(write_cmd_addr));
		end

	assert property (@(posedge clock) disable iff (!rstn)
		(write_cmd_valid && in_table(write_cmd_addr, PROPERTY_BASE))
		|-> degree_at(write_cmd_addr) != '0)
		else begin
			write_errors++;
			$display("write at %0t targets zero-degree vertex at %h", $time,
				$sampled(write_cmd_addr));
		end

	assert property (@(posedge clock) disable iff (!rstn)
		(write_cmd_valid && in_table(write_cmd_addr, PROPERTY_BASE))
		|-> write_data == updated_property(write_cmd_addr))
		else begin
			write_errors++;
			$display("error at %0t: write_data = %h, expected %h", $time,
				$sampled(write_data), updated_property($sampled(write_cmd_addr)));
		end

	// commands only leave after a cycle with room in the buffer
	assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> !$past(read_buffer_full))
		else begin
			read_errors++;
			$display("read command at %0t followed a full read buffer", $time);
		end

	assert property (@(posedge clock) disable iff (!rstn)
		write_cmd_valid |-> !$past(write_buffer_full))
		else begin
			write_errors++;
			$display("write command at %0t followed a full write buffer", $time);
		end

	assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> cu_return_vertices == word_t'(NUM_VERTICES))
		else begin
			done_errors++;
			$display("error at %0t: cu_return_vertices = %0d, expected %0d", $time,
				$sampled(cu_return_vertices), NUM_VERTICES);
		end

	assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> cu_return_edges == expected_edges)
		else begin
			done_errors++;
			$display("error at %0t: cu_return_edges = %0d, expected %0d", $time,
				$sampled(cu_return_edges), expected_edges);
		end

	assert property (@(posedge clock) disable iff (!rstn) cu_done |=> cu_done)
		else begin
			done_errors++;
			$display("cu_done fell at %0t before reset", $time);
		end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	// a non-zero word also completes setup, the descriptor is already in by then
	task automatic apply_configuration(input word_t value);
		if (value != '0) begin
			status_check    = 1'b0;
			expected_status = value;
			setup_done      = 1'b1;
		end
		cu_configure = value;
		wait_cycles(3);
		status_check = 1'b1;
	endtask

	initial begin
		rstn              = 1'b0;
		enabled_in        = 1'b0;
		wed_valid         = 1'b0;
		wed_num_vertices  = '0;
		wed_num_edges     = '0;
		wed_vertex_base   = '0;
		wed_property_base = '0;
		cu_configure      = '0;
		setup_done        = 1'b0;
		status_check      = 1'b0;
		expected_status   = '0;
		expected_edges    = '0;
		degree_seen       = '0;
		timed_out         = 1'b0;
		read_errors       = 0;
		write_errors      = 0;
		status_errors     = 0;
		done_errors       = 0;
		wait_cycles(8);
		rstn           = 1'b1;
		expected_edges = degree_sum();
		enabled_in     = 1'b1;
		status_check   = 1'b1;
		wait_cycles(3);

		// descriptor alone must leave the unit idle
		wed_valid         = 1'b1;
		wed_num_vertices  = word_t'(NUM_VERTICES);
		wed_num_edges     = expected_edges;
		wed_vertex_base   = VERTEX_BASE;
		wed_property_base = PROPERTY_BASE;
		wait_cycles(1);
		wed_valid = 1'b0;
		wait_cycles(12);

		apply_configuration(32'h0000_00a5);
		wait_cycles(20);
		apply_configuration('0);
		wait_cycles(10);
		apply_configuration(32'h5c3e_0001);
		apply_configuration('0);

		wait_count = 0;
		while (!cu_done && wait_count < DONE_TIMEOUT) begin
			wait_cycles(1);
			wait_count++;
		end
		if (!cu_done) begin
			timed_out = 1'b1;
			done_errors++;
			$display("cu_done did not rise within %0d cycles", DONE_TIMEOUT);
		end else begin
			// watch done stay high for a while
			wait_cycles(20);
			assert (degree_seen == '1)
				else begin
					read_errors++;
					$display("not every vertex degree was read");
				end
		end

		$display("errors: read %0d, write %0d, status %0d, done %0d",
			read_errors, write_errors, status_errors, done_errors);
		if (!timed_out && read_errors + write_errors + status_errors + done_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- tb_mem_model.sv
/* testbench memory model with degree and property tables, in-order tagged
   read responses after random delays and random buffer-full levels */

`timescale 1ns/100ps

module tb_mem_model #(
	parameter int          NUM_VERTICES  = 16,
	parameter logic [31:0] VERTEX_BASE   = 32'h0,
	parameter logic [31:0] PROPERTY_BASE = 32'h0,
	parameter logic [31:0] SEED          = 32'h0
) (
	input  logic           clock,
	input  logic           read_cmd_valid,
	input  cu_pkg::addr_t  read_cmd_addr,
	input  cu_pkg::cu_id_e read_cmd_cu_id,
	output logic           read_buffer_full,
	output logic           read_data_valid,
	output cu_pkg::cu_id_e read_data_cu_id,
	output cu_pkg::word_t  read_data,
	output logic           write_buffer_full
);
	import cu_pkg::*;

	localparam addr_t TABLE_BYTES = addr_t'(NUM_VERTICES * WORD_BYTES);

	word_t  degree_table   [NUM_VERTICES];
	word_t  property_table [NUM_VERTICES];
	integer seed;
	int     cycle;
	// pending responses in issue order, so each tag stays in order too
	word_t  pend_data [$];
	cu_id_e pend_id   [$];
	int     pend_due  [$];

	function automatic word_t lookup(input addr_t addr);
		if (addr >= VERTEX_BASE && addr < VERTEX_BASE + TABLE_BYTES) begin
			return degree_table[int'((addr - VERTEX_BASE) / addr_t'(WORD_BYTES))];
		end
		if (addr >= PROPERTY_BASE && addr < PROPERTY_BASE + TABLE_BYTES) begin
			return property_table[int'((addr - PROPERTY_BASE) / addr_t'(WORD_BYTES))];
		end
		return 32'hdead_beef;
	endfunction

	////////////////////////////////////////
	// tables and response loop
	////////////////////////////////////////

	initial begin
		seed              = SEED;
		cycle             = 0;
		read_buffer_full  = 1'b0;
		write_buffer_full = 1'b0;
		read_data_valid   = 1'b0;
		read_data_cu_id   = CU_ID_VERTEX_JOB;
		read_data         = '0;
		for (int i = 0; i < NUM_VERTICES; i++) begin
			degree_table[i]   = word_t'($random(seed) & 15);
			property_table[i] = word_t'($random(seed));
			// some vertices always have no edges
			if (i % 5 == 2) begin
				degree_table[i] = '0;
			end
		end
		forever begin
			@(posedge clock);
			cycle++;
			if (read_cmd_valid) begin
				pend_data.push_back(lookup(read_cmd_addr));
				pend_id.push_back(read_cmd_cu_id);
				pend_due.push_back(cycle + 1 + ($random(seed) & 7));
			end
			#1;
			read_data_valid = 1'b0;
			if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
				read_data_valid = 1'b1;
				read_data_cu_id = pend_id.pop_front();
				read_data       = pend_data.pop_front();
				pend_due.delete(0);
			end
			read_buffer_full  = (($random(seed) & 3) == 0);
			write_buffer_full = (($random(seed) & 3) == 0);
		end
	end

endmodule

//--- cu_control.sv
/* top level of the graph compute unit control block, instances only */

`timescale 1ns/100ps

module cu_control (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic           wed_valid,
	input  cu_pkg::word_t  wed_num_vertices,
	input  cu_pkg::word_t  wed_num_edges,
	input  cu_pkg::addr_t  wed_vertex_base,
	input  cu_pkg::addr_t  wed_property_base,
	input  cu_pkg::word_t  cu_configure,
	output logic           read_cmd_valid,
	output cu_pkg::addr_t  read_cmd_addr,
	output cu_pkg::cu_id_e read_cmd_cu_id,
	input  logic           read_buffer_full,
	input  logic           read_data_valid,
	input  cu_pkg::cu_id_e read_data_cu_id,
	input  cu_pkg::word_t  read_data,
	output logic           write_cmd_valid,
	output cu_pkg::addr_t  write_cmd_addr,
	output cu_pkg::word_t  write_data,
	input  logic           write_buffer_full,
	output logic           cu_done,
	output cu_pkg::word_t  cu_status,
	output cu_pkg::word_t  cu_return_vertices,
	output cu_pkg::word_t  cu_return_edges
);
	import cu_pkg::*;

	logic  cu_ready;
	word_t num_vertices;
	word_t num_edges;
	addr_t vertex_base;
	addr_t property_base;
	logic  vj_data_valid;
	logic  algo_data_valid;
	word_t data_word;
	word_t filtered_count;
	word_t vertex_done_count;
	word_t edge_done_count;

	// requester 0 is the vertex job stage, requester 1 the algorithm stage
	read_cmd_if rd_if [NUM_READ_REQUESTERS] ();
	vertex_if   unfiltered_if ();
	vertex_if   filtered_if ();

	cu_input_stage u_input_stage (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.wed_valid        (wed_valid),
		.wed_num_vertices (wed_num_vertices),
		.wed_num_edges    (wed_num_edges),
		.wed_vertex_base  (wed_vertex_base),
		.wed_property_base(wed_property_base),
		.cu_configure     (cu_configure),
		.read_data_valid  (read_data_valid),
		.read_data_cu_id  (read_data_cu_id),
		.read_data        (read_data),
		.cu_ready         (cu_ready),
		.num_vertices     (num_vertices),
		.num_edges        (num_edges),
		.vertex_base      (vertex_base),
		.property_base    (property_base),
		.cu_status        (cu_status),
		.vj_data_valid    (vj_data_valid),
		.algo_data_valid  (algo_data_valid),
		.data_word        (data_word)
	);

	read_command_arbiter #(
		.NUM_REQUESTS(NUM_READ_REQUESTERS)
	) u_read_command_arbiter (
		.clock           (clock),
		.rstn            (rstn),
		.read_buffer_full(read_buffer_full),
		.req             (rd_if),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd_addr   (read_cmd_addr),
		.read_cmd_cu_id  (read_cmd_cu_id)
	);

	vertex_job_control u_vertex_job_control (
		.clock        (clock),
		.rstn         (rstn),
		.cu_ready     (cu_ready),
		.num_vertices (num_vertices),
		.vertex_base  (vertex_base),
		.vj_data_valid(vj_data_valid),
		.data_word    (data_word),
		.rd_cmd       (rd_if[0]),
		.vertex       (unfiltered_if)
	);

	vertex_job_filter u_vertex_job_filter (
		.clock         (clock),
		.rstn          (rstn),
		.vertex_in     (unfiltered_if),
		.vertex_out    (filtered_if),
		.filtered_count(filtered_count)
	);

	graph_algorithm_control u_graph_algorithm_control (
		.clock            (clock),
		.rstn             (rstn),
		.property_base    (property_base),
		.algo_data_valid  (algo_data_valid),
		.data_word        (data_word),
		.write_buffer_full(write_buffer_full),
		.vertex_job       (filtered_if),
		.rd_cmd           (rd_if[1]),
		.write_cmd_valid  (write_cmd_valid),
		.write_cmd_addr   (write_cmd_addr),
		.write_data       (write_data),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

	cu_completion u_cu_completion (
		.clock             (clock),
		.rstn              (rstn),
		.num_vertices      (num_vertices),
		.num_edges         (num_edges),
		.filtered_count    (filtered_count),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count),
		.cu_done           (cu_done),
		.cu_return_vertices(cu_return_vertices),
		.cu_return_edges   (cu_return_edges)
	);

endmodule

//--- cu_completion.sv
/* vertex and edge totals, sticky done detection and return values */

`timescale 1ns/100ps

module cu_completion (
	input  logic          clock,
	input  logic          rstn,
	input  cu_pkg::word_t num_vertices,
	input  cu_pkg::word_t num_edges,
	input  cu_pkg::word_t filtered_count,
	input  cu_pkg::word_t vertex_done_count,
	input  cu_pkg::word_t edge_done_count,
	output logic          cu_done,
	output cu_pkg::word_t cu_return_vertices,
	output cu_pkg::word_t cu_return_edges
);
	logic totals_match;

	// a zero vertex count means no descriptor has been taken yet
	assign totals_match = (num_vertices != '0)
		&& (cu_return_vertices == num_vertices)
		&& (cu_return_edges == num_edges);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_done            <= 1'b0;
		end else begin
			cu_return_vertices <= vertex_done_count + filtered_count;
			cu_return_edges    <= edge_done_count;
			if (totals_match) begin
				cu_done <= 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) cu_done |=> cu_done)
		else $error("cu_done fell before reset");

endmodule

//--- graph_algorithm_control.sv
/* per-job property read, degree update and write-back, with
   processed vertex and edge counters */

`timescale 1ns/100ps

module graph_algorithm_control (
	input  logic          clock,
	input  logic          rstn,
	input  cu_pkg::addr_t property_base,
	input  logic          algo_data_valid,
	input  cu_pkg::word_t data_word,
	input  logic          write_buffer_full,
	vertex_if.consumer    vertex_job,
	read_cmd_if.requester rd_cmd,
	output logic          write_cmd_valid,
	output cu_pkg::addr_t write_cmd_addr,
	output cu_pkg::word_t write_data,
	output cu_pkg::word_t vertex_done_count,
	output cu_pkg::word_t edge_done_count
);
	import cu_pkg::*;

	algo_state_e state;
	logic        cmd_valid;
	logic        job_take;
	addr_t       prop_addr;
	word_t       job_degree;

	assign vertex_job.ready = (state == ALGO_IDLE);
	assign job_take         = vertex_job.valid && vertex_job.ready;

	assign rd_cmd.valid = cmd_valid;
	assign rd_cmd.addr  = prop_addr;
	assign rd_cmd.cu_id = CU_ID_ALGORITHM;

	// write-back goes to the address that was read
	assign write_cmd_addr = prop_addr;

	////////////////////////////////////////
	// one job at a time
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state             <= ALGO_IDLE;
			cmd_valid         <= 1'b0;
			write_cmd_valid   <= 1'b0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			write_cmd_valid <= 1'b0;
			case (state)
				ALGO_IDLE: begin
					if (job_take) begin
						cmd_valid <= 1'b1;
						state     <= ALGO_READ;
					end
				end
				ALGO_READ: begin
					if (rd_cmd.grant) begin
						cmd_valid <= 1'b0;
						state     <= ALGO_WAIT_DATA;
					end
				end
				ALGO_WAIT_DATA: begin
					if (algo_data_valid) begin
						state <= ALGO_WRITE;
					end
				end
				ALGO_WRITE: begin
					// hold here while the write buffer is full
					if (!write_buffer_full) begin
						write_cmd_valid   <= 1'b1;
						vertex_done_count <= vertex_done_count + 1'b1;
						edge_done_count   <= edge_done_count + job_degree;
						state             <= ALGO_IDLE;
					end
				end
				default: begin
					state <= ALGO_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (job_take) begin
			prop_addr  <= property_base + addr_t'(vertex_job.id) * addr_t'(WORD_BYTES);
			job_degree <= vertex_job.degree;
		end
		if (state == ALGO_WAIT_DATA && algo_data_valid) begin
			write_data <= data_word + job_degree;
		end
	end

endmodule

//--- vertex_job_filter.sv
/* zero-degree vertex job filter with a count of dropped jobs */

`timescale 1ns/100ps

module vertex_job_filter (
	input  logic          clock,
	input  logic          rstn,
	vertex_if.consumer    vertex_in,
	vertex_if.producer    vertex_out,
	output cu_pkg::word_t filtered_count
);
	import cu_pkg::*;

	logic zero_degree;

	assign zero_degree = (vertex_in.degree == '0);

	// zero-degree jobs are always taken and never forwarded
	assign vertex_out.valid  = vertex_in.valid && !zero_degree;
	assign vertex_out.id     = vertex_in.id;
	assign vertex_out.degree = vertex_in.degree;
	assign vertex_in.ready   = zero_degree || vertex_out.ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			filtered_count <= '0;
		end else if (vertex_in.valid && zero_degree) begin
			filtered_count <= filtered_count + 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		(vertex_out.valid && vertex_out.ready) |-> (vertex_out.degree != '0))
		else $error("zero-degree job reached the algorithm stage");

endmodule

//--- vertex_job_control.sv
/* degree read issue for every vertex, returned degree buffer and
   in-order numbering of vertex jobs */

`timescale 1ns/100ps

module vertex_job_control (
	input  logic          clock,
	input  logic          rstn,
	input  logic          cu_ready,
	input  cu_pkg::word_t num_vertices,
	input  cu_pkg::addr_t vertex_base,
	input  logic          vj_data_valid,
	input  cu_pkg::word_t data_word,
	read_cmd_if.requester rd_cmd,
	vertex_if.producer    vertex
);
	import cu_pkg::*;

	vertex_state_e           state;
	word_t                   next_id;
	word_t                   job_id;
	logic                    cmd_valid;
	addr_t                   cmd_addr;
	logic [VERTEX_CNT_W-1:0] outstanding;
	logic [VERTEX_CNT_W-1:0] fifo_count;
	logic [VERTEX_PTR_W-1:0] wr_ptr;
	logic [VERTEX_PTR_W-1:0] rd_ptr;
	word_t                   degree_mem [VERTEX_READS_MAX];
	logic                    issue;
	logic                    pop;

	function automatic logic [VERTEX_PTR_W-1:0] ptr_next(input logic [VERTEX_PTR_W-1:0] p);
		return (p == VERTEX_PTR_W'(VERTEX_READS_MAX - 1)) ? '0 : p + 1'b1;
	endfunction

	// outstanding covers a read from issue until its job is handed on,
	// so the degree buffer can never overflow
	assign issue = (state == VJ_RUN) && (!cmd_valid || rd_cmd.grant)
		&& (next_id < num_vertices)
		&& (outstanding < VERTEX_CNT_W'(VERTEX_READS_MAX));
	assign pop = vertex.valid && vertex.ready;

	assign rd_cmd.valid = cmd_valid;
	assign rd_cmd.addr  = cmd_addr;
	assign rd_cmd.cu_id = CU_ID_VERTEX_JOB;

	assign vertex.valid  = (fifo_count != '0);
	assign vertex.id     = job_id;
	assign vertex.degree = degree_mem[rd_ptr];

	////////////////////////////////////////
	// read issue FSM
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= VJ_IDLE;
			next_id     <= '0;
			cmd_valid   <= 1'b0;
			outstanding <= '0;
		end else begin
			case (state)
				VJ_IDLE: begin
					if (cu_ready) begin
						state <= VJ_RUN;
					end
				end
				VJ_RUN: begin
					if (next_id == num_vertices && outstanding == '0) begin
						state <= VJ_FINISHED;
					end
				end
				default: begin
				end
			endcase
			if (issue) begin
				cmd_valid <= 1'b1;
				next_id   <= next_id + 1'b1;
			end else if (rd_cmd.grant) begin
				cmd_valid <= 1'b0;
			end
			outstanding <= outstanding + VERTEX_CNT_W'(issue) - VERTEX_CNT_W'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd_addr <= vertex_base + addr_t'(next_id) * addr_t'(WORD_BYTES);
		end
		if (vj_data_valid) begin
			degree_mem[wr_ptr] <= data_word;
		end
	end

	////////////////////////////////////////
	// returned degrees become jobs
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fifo_count <= '0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			job_id     <= '0;
		end else begin
			fifo_count <= fifo_count + VERTEX_CNT_W'(vj_data_valid) - VERTEX_CNT_W'(pop);
			if (vj_data_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			// degrees return in issue order, so the job id is a running count
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
				job_id <= job_id + 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= VERTEX_CNT_W'(VERTEX_READS_MAX))
		else $error("degree reads in flight exceed the limit");

endmodule

//--- read_command_arbiter.sv
/* round-robin arbiter placing one read command per free cycle on the port */

`timescale 1ns/100ps

module read_command_arbiter #(
	parameter int NUM_REQUESTS = cu_pkg::NUM_READ_REQUESTERS
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           read_buffer_full,
	read_cmd_if.arbiter    req [NUM_REQUESTS],
	output logic           read_cmd_valid,
	output cu_pkg::addr_t  read_cmd_addr,
	output cu_pkg::cu_id_e read_cmd_cu_id
);
	import cu_pkg::*;

	typedef logic [$clog2(NUM_REQUESTS)-1:0] ptr_t;

	logic [NUM_REQUESTS-1:0] req_valid;
	logic [NUM_REQUESTS-1:0] grant;
	addr_t                   req_addr [NUM_REQUESTS];
	cu_id_e                  req_id   [NUM_REQUESTS];
	ptr_t                    ptr;
	ptr_t                    winner;

	for (genvar i = 0; i < NUM_REQUESTS; i++) begin : g_req
		assign req_valid[i]  = req[i].valid;
		assign req_addr[i]   = req[i].addr;
		assign req_id[i]     = req[i].cu_id;
		assign req[i].grant  = grant[i];
	end

	// first requester at or after the pointer wins
	always_comb begin
		int idx;
		winner = ptr;
		grant  = '0;
		for (int k = NUM_REQUESTS - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % NUM_REQUESTS;
			if (req_valid[idx]) begin
				winner = ptr_t'(idx);
			end
		end
		if (!read_buffer_full && (req_valid != '0)) begin
			grant[winner] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ptr            <= '0;
			read_cmd_valid <= 1'b0;
			read_cmd_addr  <= '0;
			read_cmd_cu_id <= CU_ID_VERTEX_JOB;
		end else begin
			read_cmd_valid <= (grant != '0);
			if (grant != '0) begin
				read_cmd_addr  <= req_addr[winner];
				read_cmd_cu_id <= req_id[winner];
				ptr <= (winner == ptr_t'(NUM_REQUESTS - 1)) ? '0 : winner + 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(grant))
		else $error("read arbiter granted more than one requester");

endmodule

//--- cu_input_stage.sv
/* enable register, descriptor and configuration capture, readiness
   and tag based routing of returned read data */

`timescale 1ns/100ps

module cu_input_stage (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic           wed_valid,
	input  cu_pkg::word_t  wed_num_vertices,
	input  cu_pkg::word_t  wed_num_edges,
	input  cu_pkg::addr_t  wed_vertex_base,
	input  cu_pkg::addr_t  wed_property_base,
	input  cu_pkg::word_t  cu_configure,
	input  logic           read_data_valid,
	input  cu_pkg::cu_id_e read_data_cu_id,
	input  cu_pkg::word_t  read_data,
	output logic           cu_ready,
	output cu_pkg::word_t  num_vertices,
	output cu_pkg::word_t  num_edges,
	output cu_pkg::addr_t  vertex_base,
	output cu_pkg::addr_t  property_base,
	output cu_pkg::word_t  cu_status,
	output logic           vj_data_valid,
	output logic           algo_data_valid,
	output cu_pkg::word_t  data_word
);
	import cu_pkg::*;

	logic   enabled;
	logic   wed_held;
	logic   rd_valid_q;
	cu_id_e rd_cu_id_q;
	word_t  rd_data_q;

	////////////////////////////////////////
	// descriptor and configuration
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled       <= 1'b0;
			wed_held      <= 1'b0;
			cu_ready      <= 1'b0;
			cu_status     <= '0;
			num_vertices  <= '0;
			num_edges     <= '0;
			vertex_base   <= '0;
			property_base <= '0;
		end else begin
			enabled  <= enabled_in;
			cu_ready <= wed_held && (cu_status != '0);
			if (enabled) begin
				// only the first descriptor after reset is taken
				if (wed_valid && !wed_held) begin
					wed_held      <= 1'b1;
					num_vertices  <= wed_num_vertices;
					num_edges     <= wed_num_edges;
					vertex_base   <= wed_vertex_base;
					property_base <= wed_property_base;
				end
				if (cu_configure != '0) begin
					cu_status <= cu_configure;
				end
			end
		end
	end

	////////////////////////////////////////
	// read data routing
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_valid_q      <= 1'b0;
			vj_data_valid   <= 1'b0;
			algo_data_valid <= 1'b0;
		end else begin
			rd_valid_q      <= enabled && read_data_valid;
			vj_data_valid   <= rd_valid_q && (rd_cu_id_q == CU_ID_VERTEX_JOB);
			algo_data_valid <= rd_valid_q && (rd_cu_id_q == CU_ID_ALGORITHM);
		end
	end

	// one data word shared by both strobes
	always_ff @(posedge clock) begin
		rd_cu_id_q <= read_data_cu_id;
		rd_data_q  <= read_data;
		data_word  <= rd_data_q;
	end

endmodule

//--- cu_if.sv
/* read command request/grant interface and vertex job valid/ready interface */

`timescale 1ns/100ps

// one read command source towards the arbiter
interface read_cmd_if;
	import cu_pkg::*;

	logic   valid;
	addr_t  addr;
	cu_id_e cu_id;
	logic   grant;

	modport requester (
		output valid,
		output addr,
		output cu_id,
		input  grant
	);

	modport arbiter (
		input  valid,
		input  addr,
		input  cu_id,
		output grant
	);
endinterface

// vertex job, moves when valid and ready are both high
interface vertex_if;
	import cu_pkg::*;

	logic  valid;
	word_t id;
	word_t degree;
	logic  ready;

	modport producer (
		output valid,
		output id,
		output degree,
		input  ready
	);

	modport consumer (
		input  valid,
		input  id,
		input  degree,
		output ready
	);
endinterface

//--- cu_pkg.sv
/* shared widths, unit ids, FSM state enums and table stride constants
   for the graph compute unit control block */

package cu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// tag carried by read commands and read data
	typedef enum logic {
		CU_ID_VERTEX_JOB = 1'b0,
		CU_ID_ALGORITHM  = 1'b1
	} cu_id_e;

	typedef enum logic [1:0] {
		VJ_IDLE     = 2'd0,
		VJ_RUN      = 2'd1,
		VJ_FINISHED = 2'd2
	} vertex_state_e;

	typedef enum logic [1:0] {
		ALGO_IDLE      = 2'd0,
		ALGO_READ      = 2'd1,
		ALGO_WAIT_DATA = 2'd2,
		ALGO_WRITE     = 2'd3
	} algo_state_e;

	// byte stride between entries of the degree and property tables
	localparam int WORD_BYTES = 4;

	// degree reads in flight, also the depth of the returned degree buffer
	localparam int VERTEX_READS_MAX = 4;
	localparam int VERTEX_PTR_W     = $clog2(VERTEX_READS_MAX);
	localparam int VERTEX_CNT_W     = $clog2(VERTEX_READS_MAX + 1);

	localparam int NUM_READ_REQUESTERS = 2;

endpackage
